// ==== ex_alu_unit.sv ====
/*
 * ALU unit
 *   add, subtract, logic, shifts, set-less-than
 *   registered result and four-phase write-back request
 */
`timescale 1ns/100ps

module ex_alu_unit import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start_i,
  input  ex_op_e    op_i,
  input  data_t     operand_a_i,
  input  data_t     operand_b_i,
  input  reg_addr_t waddr_i,
  output logic      idle_o,
  wb_req_if.unit    wb
);

  typedef enum logic [1:0] {S_IDLE, S_HOLD, S_REQ, S_WAIT} state_e;

  state_e               state_q;
  data_t                alu_res;
  data_t                res_q;
  reg_addr_t            waddr_q;
  logic [SHAMT_W-1:0]   shamt;

  assign shamt = operand_b_i[SHAMT_W-1:0];

  always_comb begin
    case (op_i)
      OP_ADD:  alu_res = operand_a_i + operand_b_i;
      OP_SUB:  alu_res = operand_a_i - operand_b_i;
      OP_AND:  alu_res = operand_a_i & operand_b_i;
      OP_OR:   alu_res = operand_a_i | operand_b_i;
      OP_XOR:  alu_res = operand_a_i ^ operand_b_i;
      OP_SLL:  alu_res = operand_a_i << shamt;
      OP_SRL:  alu_res = operand_a_i >> shamt;
      OP_SRA:  alu_res = data_t'($signed(operand_a_i) >>> shamt);
      OP_SLT:  alu_res = data_t'($signed(operand_a_i) < $signed(operand_b_i));
      OP_SLTU: alu_res = data_t'(operand_a_i < operand_b_i);
      default: alu_res = '0;  // MUL and DOT never steered here
    endcase
  end

  ////////////////////
  // Control FSM
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: if (start_i) state_q <= S_HOLD;
        S_HOLD: state_q <= S_REQ;             // Result settles one cycle
        S_REQ:  if (wb.ack) state_q <= S_WAIT;
        S_WAIT: if (!wb.ack) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start_i && idle_o) begin
      res_q   <= alu_res;
      waddr_q <= waddr_i;
    end
  end

  assign idle_o   = (state_q == S_IDLE);
  assign wb.req   = (state_q == S_REQ);
  assign wb.waddr = waddr_q;
  assign wb.wdata = res_q;

endmodule

// ==== ex_dot_unit.sv ====
/*
 * Dot-product unit
 *   weight and activation SPRs loaded from the LSU read data
 *   signed byte products, one register stage, then sum with accumulator
 *   four-phase write-back request
 */
`timescale 1ns/100ps

module ex_dot_unit import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start_i,
  input  data_t     operand_a_i,
  input  data_t     operand_b_i,
  input  reg_addr_t waddr_i,
  input  logic      spr_we_i,
  input  spr_sel_t  spr_sel_i,
  input  data_t     spr_wdata_i,
  output logic      idle_o,
  wb_req_if.unit    wb
);

  typedef enum logic [2:0] {S_IDLE, S_PROD, S_SUM, S_REQ, S_WAIT} state_e;

  state_e     state_q;
  data_t      wspr_q [N_WSPR];
  data_t      aspr_q [N_ASPR];
  wspr_idx_t  w_sel;
  aspr_idx_t  a_sel;
  data_t      w_word;
  data_t      a_word;
  dot_prod_t  prod_q [DOT_LANES];
  data_t      acc_q;
  data_t      dot_sum;
  data_t      res_q;
  reg_addr_t  waddr_q;

  assign w_sel  = operand_a_i[$bits(wspr_idx_t)-1:0];  // Bits [1:0]
  assign a_sel  = operand_a_i[2];
  assign w_word = wspr_q[w_sel];
  assign a_word = aspr_q[a_sel];

  ////////////////////
  // SPR file
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wspr_q <= '{default: '0};
      aspr_q <= '{default: '0};
    end else if (spr_we_i) begin
      if (spr_sel_i.act) aspr_q[aspr_idx_t'(spr_sel_i.idx)] <= spr_wdata_i;
      else               wspr_q[spr_sel_i.idx]             <= spr_wdata_i;
    end
  end

  // Lane products sign extended into the accumulator, wraps mod 2^XLEN
  always_comb begin
    dot_sum = acc_q;
    for (int l = 0; l < DOT_LANES; l++) begin
      dot_sum = dot_sum + data_t'(prod_q[l]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: if (start_i) state_q <= S_PROD;
        S_PROD: state_q <= S_SUM;
        S_SUM:  state_q <= S_REQ;
        S_REQ:  if (wb.ack) state_q <= S_WAIT;
        S_WAIT: if (!wb.ack) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start_i && idle_o) begin
      for (int l = 0; l < DOT_LANES; l++) begin
        prod_q[l] <= $signed(w_word[l*DOT_BW +: DOT_BW]) *
                     $signed(a_word[l*DOT_BW +: DOT_BW]);
      end
      acc_q   <= operand_b_i;
      waddr_q <= waddr_i;
    end
    if (state_q == S_PROD) res_q <= dot_sum;
  end

  assign idle_o   = (state_q == S_IDLE);
  assign wb.req   = (state_q == S_REQ);
  assign wb.waddr = waddr_q;
  assign wb.wdata = res_q;

endmodule

// ==== ex_mult_unit.sv ====
/*
 * Iterative multiplier unit
 *   shift-add over MUL_DIGIT wide slices of operand b
 *   low XLEN bits of the product
 *   four-phase write-back request
 */
`timescale 1ns/100ps

module ex_mult_unit import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start_i,
  input  data_t     operand_a_i,
  input  data_t     operand_b_i,
  input  reg_addr_t waddr_i,
  output logic      idle_o,
  wb_req_if.unit    wb
);

  typedef enum logic [1:0] {S_IDLE, S_RUN, S_REQ, S_WAIT} state_e;

  state_e                state_q;
  logic [MUL_CNT_W-1:0]  step_q;
  logic                  last_step;
  data_t                 acc_q;     // Partial product
  data_t                 mcand_q;   // Multiplicand, moves up one digit per step
  data_t                 mplier_q;  // Multiplier, moves down one digit per step
  data_t                 partial;
  reg_addr_t             waddr_q;

  assign partial   = mcand_q * data_t'(mplier_q[MUL_DIGIT-1:0]);
  assign last_step = (step_q == MUL_CNT_W'(MUL_STEPS - 1));

  ////////////////////
  // Control FSM
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      step_q  <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            state_q <= S_RUN;
            step_q  <= '0;
          end
        end
        S_RUN: begin
          step_q <= step_q + 1'b1;
          if (last_step) state_q <= S_REQ;  // Final digit added this edge
        end
        S_REQ:  if (wb.ack) state_q <= S_WAIT;
        S_WAIT: if (!wb.ack) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  ////////////////////
  // Datapath
  ////////////////////
  always_ff @(posedge clk) begin
    if (start_i && idle_o) begin
      acc_q    <= '0;
      mcand_q  <= operand_a_i;
      mplier_q <= operand_b_i;
      waddr_q  <= waddr_i;
    end else if (state_q == S_RUN) begin
      acc_q    <= acc_q + partial;
      mcand_q  <= mcand_q << MUL_DIGIT;
      mplier_q <= mplier_q >> MUL_DIGIT;
    end
  end

  assign idle_o   = (state_q == S_IDLE);
  assign wb.req   = (state_q == S_REQ);
  assign wb.waddr = waddr_q;
  assign wb.wdata = acc_q;

endmodule

// ==== ex_pkg.sv ====
/*
 * Execute stage shared definitions
 *   data and register address widths
 *   operation codes and unit identifiers, with the op to unit mapping
 *   multiplier step sizes
 *   dot-product SPR index and select types, lane sizes
 */
package ex_pkg;

  localparam int XLEN    = 32;
  localparam int REG_AW  = 6;
  localparam int SHAMT_W = $clog2(XLEN);  // Shift amount bits

  typedef logic [XLEN-1:0]   data_t;
  typedef logic [REG_AW-1:0] reg_addr_t;

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLL  = 4'd5,
    OP_SRL  = 4'd6,
    OP_SRA  = 4'd7,
    OP_SLT  = 4'd8,
    OP_SLTU = 4'd9,
    OP_MUL  = 4'd10,
    OP_DOT  = 4'd11
  } ex_op_e;

  typedef enum logic [1:0] {
    UNIT_ALU = 2'd0,
    UNIT_MUL = 2'd1,
    UNIT_DOT = 2'd2
  } ex_unit_e;

  localparam int N_UNITS = 3;

  // Iterative multiplier
  localparam int MUL_DIGIT = 8;                  // Multiplier bits per step
  localparam int MUL_STEPS = XLEN / MUL_DIGIT;
  localparam int MUL_CNT_W = $clog2(MUL_STEPS);

  // Dot-product SPRs and lanes
  localparam int N_WSPR    = 4;
  localparam int N_ASPR    = 2;
  localparam int DOT_LANES = 4;
  localparam int DOT_BW    = XLEN / DOT_LANES;   // Bits per lane

  typedef logic [$clog2(N_WSPR)-1:0] wspr_idx_t;
  typedef logic [$clog2(N_ASPR)-1:0] aspr_idx_t;
  typedef logic signed [2*DOT_BW-1:0] dot_prod_t;

  typedef struct packed {
    logic      act;  // 1 for activation, 0 for weight
    wspr_idx_t idx;
  } spr_sel_t;

  function automatic ex_unit_e unit_of(ex_op_e op);
    case (op)
      OP_MUL:  return UNIT_MUL;
      OP_DOT:  return UNIT_DOT;
      default: return UNIT_ALU;
    endcase
  endfunction

endpackage

// ==== ex_stage.f ====
ex_pkg.sv
wb_req_if.sv
ex_alu_unit.sv
ex_mult_unit.sv
ex_dot_unit.sv
ex_wb_arbiter.sv
ex_stage.sv
tb_ex_stage.sv

// ==== ex_stage.sv ====
/*
 * Execute stage top level
 *   valid/ready issue steered to the ALU, multiplier or dot unit
 *   SPR load port into the dot unit
 *   shared write-back port through the round-robin arbiter
 */
`timescale 1ns/100ps

module ex_stage import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // Issue
  input  logic      op_valid_i,
  output logic      op_ready_o,
  input  ex_op_e    op_i,
  input  data_t     operand_a_i,
  input  data_t     operand_b_i,
  input  reg_addr_t waddr_i,
  // SPR load from LSU
  input  logic      spr_we_i,
  input  spr_sel_t  spr_sel_i,
  input  data_t     spr_wdata_i,
  // Write-back
  input  logic      wb_ready_i,
  output logic      wb_we_o,
  output reg_addr_t wb_waddr_o,
  output data_t     wb_wdata_o
);

  ex_unit_e           sel_unit;
  logic [N_UNITS-1:0] unit_idle;
  logic               accept;
  logic               start_alu;
  logic               start_mul;
  logic               start_dot;

  wb_req_if alu_wb ();
  wb_req_if mul_wb ();
  wb_req_if dot_wb ();

  assign sel_unit   = unit_of(op_i);
  assign op_ready_o = unit_idle[sel_unit];  // Only the target unit matters
  assign accept     = op_valid_i && op_ready_o;
  assign start_alu  = accept && (sel_unit == UNIT_ALU);
  assign start_mul  = accept && (sel_unit == UNIT_MUL);
  assign start_dot  = accept && (sel_unit == UNIT_DOT);

  ex_alu_unit u_alu (
    .clk, .rst_n, .start_i(start_alu), .op_i, .operand_a_i, .operand_b_i,
    .waddr_i, .idle_o(unit_idle[UNIT_ALU]), .wb(alu_wb)
  );

  ex_mult_unit u_mul (
    .clk, .rst_n, .start_i(start_mul), .operand_a_i, .operand_b_i,
    .waddr_i, .idle_o(unit_idle[UNIT_MUL]), .wb(mul_wb)
  );

  ex_dot_unit u_dot (
    .clk, .rst_n, .start_i(start_dot), .operand_a_i, .operand_b_i,
    .waddr_i, .spr_we_i, .spr_sel_i, .spr_wdata_i,
    .idle_o(unit_idle[UNIT_DOT]), .wb(dot_wb)
  );

  ex_wb_arbiter u_arb (
    .clk, .rst_n, .wb_ready_i,
    .alu(alu_wb), .mul(mul_wb), .dot(dot_wb),
    .wb_we_o, .wb_waddr_o, .wb_wdata_o
  );

endmodule

// ==== ex_wb_arbiter.sv ====
/*
 * Write-back arbiter
 *   round-robin grant over the unit request channels
 *   one ack register per unit, four-phase release
 *   registered write-back port, one pulse per grant
 */
`timescale 1ns/100ps

module ex_wb_arbiter import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      wb_ready_i,
  wb_req_if.arb     alu,
  wb_req_if.arb     mul,
  wb_req_if.arb     dot,
  output logic      wb_we_o,
  output reg_addr_t wb_waddr_o,
  output data_t     wb_wdata_o
);

  logic [N_UNITS-1:0] req;
  reg_addr_t          waddr [N_UNITS];
  data_t              wdata [N_UNITS];
  logic [N_UNITS-1:0] ack_q;
  ex_unit_e           rr_q;       // Last unit granted
  ex_unit_e           gnt_unit;
  logic               gnt_valid;
  logic               grant;

  // Gather the channels by unit id
  assign req[UNIT_ALU]   = alu.req;
  assign req[UNIT_MUL]   = mul.req;
  assign req[UNIT_DOT]   = dot.req;
  assign waddr[UNIT_ALU] = alu.waddr;
  assign waddr[UNIT_MUL] = mul.waddr;
  assign waddr[UNIT_DOT] = dot.waddr;
  assign wdata[UNIT_ALU] = alu.wdata;
  assign wdata[UNIT_MUL] = mul.wdata;
  assign wdata[UNIT_DOT] = dot.wdata;

  assign alu.ack = ack_q[UNIT_ALU];
  assign mul.ack = ack_q[UNIT_MUL];
  assign dot.ack = ack_q[UNIT_DOT];

  ////////////////////
  // Round-robin pick
  ////////////////////
  always_comb begin
    int unsigned idx;
    gnt_valid = 1'b0;
    gnt_unit  = UNIT_ALU;
    for (int i = 1; i <= N_UNITS; i++) begin
      idx = (int'(rr_q) + i) % N_UNITS;  // Start after the last winner
      if (!gnt_valid && req[idx]) begin
        gnt_valid = 1'b1;
        gnt_unit  = ex_unit_e'(idx);
      end
    end
  end

  assign grant = wb_ready_i && (ack_q == '0) && gnt_valid;  // One handshake at a time

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q   <= '0;
      rr_q    <= UNIT_DOT;  // ALU has first priority
      wb_we_o <= 1'b0;
    end else begin
      wb_we_o <= grant;
      for (int i = 0; i < N_UNITS; i++) begin
        if (ack_q[i] && !req[i]) ack_q[i] <= 1'b0;  // Req gone, release
      end
      if (grant) begin
        ack_q[gnt_unit] <= 1'b1;
        rr_q            <= gnt_unit;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      wb_waddr_o <= waddr[gnt_unit];
      wb_wdata_o <= wdata[gnt_unit];
    end
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module tb_ex_stage -f ex_stage.f \
  > build.log 2>&1 &&
  ./obj_dir/Vtb_ex_stage > sim.log 2>&1 ||
  echo "Build or simulation error, see build.log and sim.log"

grep -q "^Test passed$" sim.log 2>/dev/null &&
  echo "Simulation PASS" && exit 0 ||
  { echo "Simulation FAIL, see sim.log"; exit 1; }

// ==== tb_ex_stage.sv ====
/*
 * Testbench for the execute stage
 *   clock, reset and LFSR stimulus driven on the falling edge
 *   SPR model and reference function for expected results
 *   write-back scoreboard indexed by destination address
 *   back-pressure on the write-back port and a cycle limit
 */
`timescale 1ns/100ps

module tb_ex_stage import ex_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int N_OPS      = 320;                         // Rough count over all tests
  localparam int WORST_LAT  = 12;                          // Cycles per op under back-pressure
  localparam int MAX_CYCLES = N_OPS * WORST_LAT + 2160;

  logic      clk;
  logic      rst_n;
  logic      op_valid_i;
  logic      op_ready_o;
  ex_op_e    op_i;
  data_t     operand_a_i;
  data_t     operand_b_i;
  reg_addr_t waddr_i;
  logic      spr_we_i;
  spr_sel_t  spr_sel_i;
  data_t     spr_wdata_i;
  logic      wb_ready_i;
  logic      wb_we_o;
  reg_addr_t wb_waddr_o;
  data_t     wb_wdata_o;

  data_t       wspr_m [N_WSPR];      // SPR model
  data_t       aspr_m [N_ASPR];
  data_t       exp_data [2**REG_AW];  // Scoreboard by waddr
  string       exp_name [2**REG_AW];
  bit          pending  [2**REG_AW];
  int          n_pending = 0;
  int          n_errors  = 0;
  int          n_checks  = 0;
  int          n_wb      = 0;
  int          cycles    = 0;
  logic [31:0] lfsr;
  reg_addr_t   next_addr;
  string       cur_test;
  logic        ready_q;               // wb_ready_i as seen by the last edge
  int          stretch_q [$];

  ex_stage u_dut (
    .clk, .rst_n, .op_valid_i, .op_ready_o, .op_i, .operand_a_i, .operand_b_i,
    .waddr_i, .spr_we_i, .spr_sel_i, .spr_wdata_i, .wb_ready_i, .wb_we_o,
    .wb_waddr_o, .wb_wdata_o
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // Random source and reference
  ////////////////////
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic data_t expect_result(ex_op_e op, data_t a, data_t b);
    logic [63:0] wide;
    int          sum;
    byte         w8;
    byte         a8;
    data_t       w_word;
    data_t       a_word;
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[4:0];
      OP_SRL:  return a >> b[4:0];
      OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
      OP_SRA: begin
        wide = {{32{a[31]}}, a} >> b[4:0];  // Sign bits shifted in from the top
        return wide[31:0];
      end
      OP_MUL: begin
        wide = {32'b0, a} * {32'b0, b};
        return wide[31:0];
      end
      OP_DOT: begin
        w_word = wspr_m[a[1:0]];
        a_word = aspr_m[a[2]];
        sum    = int'(b);
        for (int l = 0; l < 4; l++) begin
          w8  = w_word[l*8 +: 8];
          a8  = a_word[l*8 +: 8];
          sum = sum + w8 * a8;
        end
        return data_t'(sum);
      end
      default: return '0;
    endcase
  endfunction

  ////////////////////
  // Checks
  ////////////////////
  task automatic check_data(string name, data_t exp, data_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_addr(reg_addr_t addr, output bit known);
    n_checks++;
    known = pending[addr];
    if (!known) begin
      n_errors++;
      $display("ERROR unexpected or duplicate write-back to register %0d at %0t", addr, $time);
    end
  endtask

  always @(posedge clk) ready_q <= wb_ready_i;

  // Scoreboard sampled on the falling edge
  always @(negedge clk) begin
    bit known;
    if (rst_n && wb_we_o) begin
      n_wb++;
      if (!ready_q) begin
        n_errors++;
        $display("ERROR write-back granted while wb_ready_i was low at %0t", $time);
      end
      check_addr(wb_waddr_o, known);
      if (known) begin
        check_data(exp_name[wb_waddr_o], exp_data[wb_waddr_o], wb_wdata_o);
        pending[wb_waddr_o] = 1'b0;
        n_pending--;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, %0d write-backs still outstanding", cycles, n_pending);
      $display("Checks %0d, errors %0d, write-backs %0d", n_checks, n_errors, n_wb);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////
  // Starts and ends on a falling edge
  task automatic issue_op(ex_op_e op, data_t a, data_t b);
    reg_addr_t addr;
    addr           = next_addr;  // Rotating address that is never still outstanding
    next_addr++;
    exp_data[addr] = expect_result(op, a, b);
    exp_name[addr] = cur_test;
    pending[addr]  = 1'b1;
    n_pending++;
    op_valid_i  = 1'b1;
    op_i        = op;
    operand_a_i = a;
    operand_b_i = b;
    waddr_i     = addr;
    @(posedge clk);
    while (!op_ready_o) @(posedge clk);  // Accepted at this edge
    @(negedge clk);
    op_valid_i = 1'b0;
  endtask

  task automatic load_spr(spr_sel_t sel, data_t val);
    spr_we_i    = 1'b1;
    spr_sel_i   = sel;
    spr_wdata_i = val;
    if (sel.act) aspr_m[sel.idx[0]] = val;
    else         wspr_m[sel.idx]    = val;
    @(negedge clk);
    spr_we_i = 1'b0;
  endtask

  task automatic idle_cycles(int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic mixed_step();
    logic [2:0] r;
    spr_sel_t   sel;
    ex_op_e     op;
    data_t      a;
    data_t      b;
    r = rand_bits(3);
    if (r == 3'd0) begin  // Occasional SPR reload
      sel = spr_sel_t'(rand_bits(3));
      a   = rand_bits(32);
      load_spr(sel, a);
    end
    op = ex_op_e'(rand_bits(4) % 12);
    a  = rand_bits(32);
    b  = rand_bits(32);
    issue_op(op, a, b);
    idle_cycles(int'(rand_bits(2)));
  endtask

  task automatic toggle_ready();
    while (stretch_q.size() != 0) begin
      wb_ready_i = ~wb_ready_i;
      idle_cycles(stretch_q.pop_front());
    end
  endtask

  initial begin
    ex_op_e op;
    data_t  a;
    data_t  b;
    lfsr        = 32'hd341_b2c0;
    rst_n       = 1'b0;
    op_valid_i  = 1'b0;
    op_i        = OP_ADD;
    operand_a_i = '0;
    operand_b_i = '0;
    waddr_i     = '0;
    spr_we_i    = 1'b0;
    spr_sel_i   = '0;
    spr_wdata_i = '0;
    wb_ready_i  = 1'b1;
    next_addr   = '0;
    cur_test    = "reset";
    wspr_m      = '{default: '0};
    aspr_m      = '{default: '0};
    pending     = '{default: 1'b0};
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    check_flag("reset wb_we_o", 1'b0, wb_we_o);
    for (int i = 0; i <= int'(OP_DOT); i++) begin
      op_i = ex_op_e'(i);
      @(negedge clk);
      check_flag("reset op_ready_o", 1'b1, op_ready_o);
    end
    @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      b = rand_bits(32);
      issue_op(OP_DOT, data_t'(i), b);  // SPRs all zero
    end

    cur_test = "alu_directed";
    for (int i = 0; i < 10; i++) begin
      a = rand_bits(32);
      b = rand_bits(32);
      issue_op(ex_op_e'(i), a, b);
    end
    issue_op(OP_SLL, 32'h8000_0001, 32'd0);
    issue_op(OP_SLL, 32'h8000_0001, 32'd31);
    issue_op(OP_SRL, 32'h8000_0001, 32'd31);
    issue_op(OP_SRA, 32'h8000_0001, 32'd31);
    issue_op(OP_SRA, 32'h8000_0001, 32'hffff_ffe0);  // Low bits give amount 0
    issue_op(OP_SLT, 32'hffff_ffff, 32'd1);
    issue_op(OP_SLTU, 32'hffff_ffff, 32'd1);

    cur_test = "alu_random";
    repeat (60) begin
      op = ex_op_e'(rand_bits(4) % 10);
      a  = rand_bits(32);
      b  = rand_bits(32);
      issue_op(op, a, b);
    end

    cur_test = "mul";
    issue_op(OP_MUL, 32'hffff_fffd, 32'hffff_fff9);
    issue_op(OP_MUL, 32'd0, 32'h1234_5678);
    issue_op(OP_MUL, 32'h8765_4321, 32'd0);
    issue_op(OP_MUL, 32'hffff_ffff, 32'd7);
    repeat (40) begin
      a = rand_bits(32);
      b = rand_bits(32);
      issue_op(OP_MUL, a, b);
    end

    cur_test = "spr_dot";
    for (int i = 0; i < N_WSPR + N_ASPR; i++) begin
      a = rand_bits(32);
      load_spr((i < N_WSPR) ? spr_sel_t'({1'b0, wspr_idx_t'(i)})
                            : spr_sel_t'({1'b1, wspr_idx_t'(i - N_WSPR)}), a);
    end
    for (int i = 0; i < 8; i++) begin
      b = rand_bits(32);
      issue_op(OP_DOT, data_t'(i), b);  // Every weight and activation pair
    end
    repeat (12) begin
      a = rand_bits(32);
      b = rand_bits(32);
      issue_op(OP_DOT, a, b);
    end

    cur_test = "mixed";
    repeat (80) mixed_step();

    cur_test = "backpressure";
    for (int i = 0; i < 40; i++) stretch_q.push_back(int'(rand_bits(4)) + 1);
    fork
      repeat (80) mixed_step();
      toggle_ready();
    join
    wb_ready_i = 1'b1;

    while (n_pending != 0) @(negedge clk);
    idle_cycles(5);
    check_flag("final wb_we_o", 1'b0, wb_we_o);
    $display("Checks %0d, errors %0d, write-backs %0d", n_checks, n_errors, n_wb);
    if (n_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== wb_req_if.sv ====
/*
 * Write-back request channel between one execute unit and the arbiter
 *   four-phase req/ack with destination address and result
 */
`timescale 1ns/100ps

interface wb_req_if import ex_pkg::*; ();

  logic      req;    // Held until ack is seen
  logic      ack;    // Held until req falls
  reg_addr_t waddr;
  data_t     wdata;

  modport unit (
    output req,
    output waddr,
    output wdata,
    input  ack
  );

  modport arb (
    input  req,
    input  waddr,
    input  wdata,
    output ack
  );

endinterface
